// ==== source/retire_pkg.sv ====
package retire_pkg;

    // Width of the largest tag the back end supports
    // Depth up to 64 entries
    localparam int max_tag_w = 6;

    // One result word from an execution unit
    typedef logic [31:0] data_t;

    // Architectural register index, x0 to x31
    typedef logic [4:0] arch_reg_t;

    // Instruction address kept with each entry
    typedef logic [9:0] pc_t;

    // Which result port the completion arbiter served last
    typedef enum logic [0:0] {
        grant_alu = 1'b0,                   // ALU port won the last grant
        grant_mul = 1'b1                    // Multiplier port won the last grant
    } arb_state_t;

    // Notes on use
    //
    // Tags are not a shared type. Each module derives its tag width
    // from its ROB_DEPTH parameter, so the depth must be a power of two
    // no larger than 2**max_tag_w.
    //
    // Entry counters are max_tag_w+1 bits wide so that a full buffer
    // can be told apart from an empty one.
    //
    // The arbiter state resets to grant_mul, which lets the ALU win
    // the first tie.
    //
    // data_t is also the width of the architectural registers and of
    // the commit value.

endpackage

// ==== source/completion_arbiter.sv ====
module completion_arbiter import retire_pkg::*; #(
    parameter int ROB_DEPTH = 16                     // Sets the tag width
) (
    input  logic                         clk,
    input  logic                         rst,
    // ALU result port
    input  logic                         alu_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] alu_tag,
    input  data_t                        alu_value,
    output logic                         alu_ready,
    // Multiplier result port
    input  logic                         mul_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] mul_tag,
    input  data_t                        mul_value,
    output logic                         mul_ready,
    // Completion bus into the reorder buffer
    output logic                         cmp_valid,
    output logic [$clog2(ROB_DEPTH)-1:0] cmp_tag,
    output data_t                        cmp_value
);

    arb_state_t last_q;                              // Port served last time
    logic       grant_alu_w;
    logic       grant_mul_w;

    // On a tie the port that lost last time goes first
    assign grant_alu_w = alu_valid && (!mul_valid || last_q == grant_mul);
    assign grant_mul_w = mul_valid && (!alu_valid || last_q == grant_alu);

    assign alu_ready = grant_alu_w;                  // Low until a request arrives
    assign mul_ready = grant_mul_w;

    // Grant history and completion strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q    <= grant_mul;                  // ALU wins the first tie
            cmp_valid <= 1'b0;
        end else begin
            cmp_valid <= grant_alu_w || grant_mul_w; // One completion per cycle
            if (grant_alu_w) begin
                last_q <= grant_alu;
            end else if (grant_mul_w) begin
                last_q <= grant_mul;
            end
        end
    end

    // Winning tag and value onto the completion bus
    always_ff @(posedge clk) begin
        if (grant_alu_w) begin
            cmp_tag   <= alu_tag;
            cmp_value <= alu_value;
        end else if (grant_mul_w) begin
            cmp_tag   <= mul_tag;
            cmp_value <= mul_value;
        end
    end

endmodule

// ==== source/reorder_buffer.sv ====
module reorder_buffer import retire_pkg::*; #(
    parameter int ROB_DEPTH = 16                     // Number of entries, power of two
) (
    input  logic                         clk,
    input  logic                         rst,
    // Allocate from decode
    input  logic                         alloc_valid,
    input  arch_reg_t                    alloc_dest,
    input  logic                         alloc_reg_write,
    input  pc_t                          alloc_pc,
    output logic                         alloc_ready,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    // Completion from the arbiter
    input  logic                         cmp_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] cmp_tag,
    input  data_t                        cmp_value,
    // Branch mispredict
    input  logic                         flush_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] flush_tag,
    // Retirement
    output logic                         commit_valid,
    output arch_reg_t                    commit_dest,
    output data_t                        commit_value,
    output logic                         commit_reg_write
);

    localparam int TAG_W = $clog2(ROB_DEPTH);        // Tag bits
    localparam int CNT_W = max_tag_w + 1;            // Live count, holds 0 to depth

    // Per-entry control bits
    logic [ROB_DEPTH-1:0] live_q;                    // Entry allocated and not yet retired
    logic [ROB_DEPTH-1:0] done_q;                    // Result written back

    // Per-entry payload
    logic [ROB_DEPTH-1:0] reg_write_q;               // Entry writes a register
    arch_reg_t            dest_q  [ROB_DEPTH];       // Destination register
    data_t                value_q [ROB_DEPTH];       // Result value

    logic [TAG_W-1:0]     head_q;                    // Oldest entry
    logic [TAG_W-1:0]     tail_q;                    // Next free slot
    logic [CNT_W-1:0]     count_q;                   // Live entries
    logic [CNT_W-1:0]     count_d;

    logic                 alloc_fire;
    logic                 commit_fire;
    logic [TAG_W-1:0]     flush_dist;                // Age of the branch entry from head
    logic [CNT_W-1:0]     flush_keep;                // Entries that survive a flush
    logic [ROB_DEPTH-1:0] flush_kill;                // Entries younger than the branch

    // Allocation is refused while full or while a flush is in flight
    assign alloc_ready = !flush_valid && (count_q != CNT_W'(ROB_DEPTH));
    assign alloc_tag   = tail_q;                     // Tag handed back to decode
    assign alloc_fire  = alloc_valid && alloc_ready;

    // Head retires once its result is in
    assign commit_fire = live_q[head_q] && done_q[head_q];

    // Branch stays, so the head up to and including it survive
    assign flush_dist = flush_tag - head_q;          // Wraps modulo depth
    assign flush_keep = CNT_W'(flush_dist) + 1'b1;

    always_comb begin
        logic [TAG_W-1:0] offset;
        offset = '0;
        for (int i = 0; i < ROB_DEPTH; i++) begin
            offset        = TAG_W'(i) - head_q;      // Age of slot i
            flush_kill[i] = offset > flush_dist;     // Younger than the branch
        end
    end

    // Next live count
    always_comb begin
        if (flush_valid) begin
            count_d = flush_keep - CNT_W'(commit_fire);
        end else begin
            count_d = count_q + CNT_W'(alloc_fire) - CNT_W'(commit_fire);
        end
    end

    // Pointers and entry status
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            live_q  <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_fire) begin
                live_q[tail_q] <= 1'b1;              // New entry, result pending
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (cmp_valid && live_q[cmp_tag]) begin
                done_q[cmp_tag] <= 1'b1;             // Stale tags are dropped
            end
            if (commit_fire) begin
                live_q[head_q] <= 1'b0;              // Slot freed
                head_q         <= head_q + 1'b1;
            end
            if (flush_valid) begin
                tail_q <= flush_tag + 1'b1;          // Cut back to just past the branch
                for (int i = 0; i < ROB_DEPTH; i++) begin
                    if (flush_kill[i]) begin
                        live_q[i] <= 1'b0;
                    end
                end
            end
            count_q <= count_d;
        end
    end

    // Entry payload, written at allocate and at completion
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            reg_write_q[tail_q] <= alloc_reg_write;
            dest_q[tail_q]      <= alloc_dest;
        end
        if (cmp_valid && live_q[cmp_tag]) begin
            value_q[cmp_tag] <= cmp_value;           // Result by tag
        end
    end

    // Commit strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= commit_fire;             // One-cycle pulse per retirement
        end
    end

    // Commit fields, only meaningful with commit_valid
    always_ff @(posedge clk) begin
        if (commit_fire) begin
            commit_dest      <= dest_q[head_q];
            commit_value     <= value_q[head_q];
            commit_reg_write <= reg_write_q[head_q];
        end
    end

endmodule

// ==== source/arch_regfile.sv ====
module arch_regfile import retire_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Commit write port
    input  logic      commit_valid,
    input  arch_reg_t commit_dest,
    input  data_t     commit_value,
    input  logic      commit_reg_write,
    // Architectural read port
    input  arch_reg_t rd_addr,
    output data_t     rd_data
);

    // x0 has no storage, it always reads zero
    data_t regs_q [1:31];
    logic  wr_en;

    // Only commits that write a real register
    assign wr_en = commit_valid && commit_reg_write && (commit_dest != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;                     // Architectural state starts cleared
            end
        end else begin
            if (wr_en) begin
                regs_q[commit_dest] <= commit_value;
            end
        end
    end

    // Combinational read, sees a commit one cycle after commit_valid
    always_comb begin
        if (rd_addr == '0) begin
            rd_data = '0;                            // Hard-wired zero
        end else begin
            rd_data = regs_q[rd_addr];
        end
    end

endmodule

// ==== source/retire_top.sv ====
module retire_top import retire_pkg::*; #(
    parameter int ROB_DEPTH = 16                     // Reorder buffer entries
) (
    input  logic                         clk,
    input  logic                         rst,
    // Allocate
    input  logic                         alloc_valid,
    input  arch_reg_t                    alloc_dest,
    input  logic                         alloc_reg_write,
    input  pc_t                          alloc_pc,
    output logic                         alloc_ready,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    // ALU results
    input  logic                         alu_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] alu_tag,
    input  data_t                        alu_value,
    output logic                         alu_ready,
    // Multiplier results
    input  logic                         mul_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] mul_tag,
    input  data_t                        mul_value,
    output logic                         mul_ready,
    // Branch flush
    input  logic                         flush_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0] flush_tag,
    // Retirement
    output logic                         commit_valid,
    output arch_reg_t                    commit_dest,
    output data_t                        commit_value,
    output logic                         commit_reg_write,
    // Register read
    input  arch_reg_t                    rd_addr,
    output data_t                        rd_data
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic             cmp_valid;                     // Arbiter to buffer
    logic [TAG_W-1:0] cmp_tag;
    data_t            cmp_value;

    completion_arbiter #(.ROB_DEPTH(ROB_DEPTH)) u_completion_arbiter (
        .clk, .rst,
        .alu_valid, .alu_tag, .alu_value, .alu_ready,
        .mul_valid, .mul_tag, .mul_value, .mul_ready,
        .cmp_valid, .cmp_tag, .cmp_value
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
        .clk, .rst,
        .alloc_valid, .alloc_dest, .alloc_reg_write, .alloc_pc, .alloc_ready, .alloc_tag,
        .cmp_valid, .cmp_tag, .cmp_value,
        .flush_valid, .flush_tag,
        .commit_valid, .commit_dest, .commit_value, .commit_reg_write
    );

    arch_regfile u_arch_regfile (
        .clk, .rst,
        .commit_valid, .commit_dest, .commit_value, .commit_reg_write,
        .rd_addr, .rd_data
    );

endmodule

// ==== verification/retire_vectors.svh ====
// Each row holds op, dest, reg_write, pc, tag a, tag b, value a, value b and expected
// Tags are allocation indices counted from zero. lcg_v draws a value from the LCG
`ifndef RETIRE_VECTORS_SVH
`define RETIRE_VECTORS_SVH

task automatic build_vectors();
    for (int i = 0; i < 6; i++) begin
        add_row(op_alloc, i + 1, 1, 'h040 + i, 0, 0, lcg_v, lcg_v, no_exp);  // Allocs 0 to 5
    end
    add_row(op_alu,  0, 0, 0, 5, 0, 32'h0000_0a06, lcg_v, no_exp);    // Youngest first
    add_row(op_mul,  0, 0, 0, 4, 0, 32'h0000_0b05, lcg_v, no_exp);
    add_row(op_alu,  0, 0, 0, 3, 0, 32'h0000_0a04, lcg_v, no_exp);
    add_row(op_mul,  0, 0, 0, 2, 0, 32'h0000_0b03, lcg_v, no_exp);
    add_row(op_alu,  0, 0, 0, 1, 0, 32'h0000_0a02, lcg_v, no_exp);
    add_row(op_mul,  0, 0, 0, 0, 0, 32'h0000_0b01, lcg_v, no_exp);    // Oldest releases all six
    add_row(op_drain, 0, 0, 0, 0, 0, lcg_v, lcg_v, no_exp);
    add_row(op_read, 1, 0, 0, 0, 0, lcg_v, lcg_v, 32'h0000_0b01);
    add_row(op_read, 6, 0, 0, 0, 0, lcg_v, lcg_v, 32'h0000_0a06);
    for (int i = 0; i < 4; i++) begin
        add_row(op_alloc, i + 7, 1, 'h060 + i, 0, 0, lcg_v, lcg_v, no_exp);  // Allocs 6 to 9
    end
    add_row(op_alu_mul, 0, 0, 0, 6, 7, lcg_v, lcg_v, no_exp);        // Both ports at once
    add_row(op_alu_mul, 0, 0, 0, 9, 8, lcg_v, lcg_v, no_exp);
    add_row(op_drain, 0, 0, 0, 0, 0, lcg_v, lcg_v, no_exp);
    for (int i = 0; i < 5; i++) begin
        add_row(op_alloc, i + 11, 1, 'h080 + i, 0, 0, lcg_v, lcg_v, no_exp); // Allocs 10 to 14
    end
    add_row(op_flush, 0, 0, 0, 11, 0, lcg_v, lcg_v, no_exp);          // Branch is alloc 11
    add_row(op_alu_mul, 0, 0, 0, 10, 11, lcg_v, lcg_v, no_exp);      // Survivors only
    add_row(op_alloc, 16, 1, 'h0a0, 0, 0, lcg_v, lcg_v, no_exp);     // Alloc 15 after branch
    add_row(op_alu, 0, 0, 0, 15, 0, lcg_v, lcg_v, no_exp);
    add_row(op_alloc, 3, 0, 'h0a1, 0, 0, lcg_v, lcg_v, no_exp);      // Alloc 16 no write
    add_row(op_alloc, 0, 1, 'h0a2, 0, 0, lcg_v, lcg_v, no_exp);      // Alloc 17 to x0
    add_row(op_alu_mul, 0, 0, 0, 16, 17, 32'hdead_0003, 32'hdead_0000, no_exp);
    add_row(op_drain, 0, 0, 0, 0, 0, lcg_v, lcg_v, no_exp);
    add_row(op_read, 3, 0, 0, 0, 0, lcg_v, lcg_v, 32'h0000_0b03);    // Unchanged
    add_row(op_read, 0, 0, 0, 0, 0, lcg_v, lcg_v, 32'h0000_0000);
    for (int i = 0; i < 16; i++) begin
        add_row(op_alloc, 20, 1, 'h100 + i, 0, 0, lcg_v, lcg_v, no_exp);    // Allocs 18 to 33
    end
    add_row(op_alloc, 21, 1, 'h110, 0, 0, lcg_v, lcg_v, 32'd1);      // Refused while full
    add_row(op_alu, 0, 0, 0, 18, 0, lcg_v, lcg_v, no_exp);           // One commit frees a slot
    add_row(op_alloc, 21, 1, 'h111, 0, 0, lcg_v, lcg_v, no_exp);     // Alloc 34
    for (int i = 19; i < 35; i++) begin
        add_row(i % 2 == 1 ? op_mul : op_alu, 0, 0, 0, i, 0, lcg_v, lcg_v, no_exp);
    end
    add_row(op_drain, 0, 0, 0, 0, 0, lcg_v, lcg_v, no_exp);
endtask

`endif

// ==== verification/tb_retire_top.sv ====
module tb_retire_top import retire_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    ROB_DEPTH = 16;
    localparam int    TAG_W     = $clog2(ROB_DEPTH);
    localparam data_t lcg_v     = 32'hffff_ffff;          // Value drawn from the LCG
    localparam data_t no_exp    = 32'hffff_ffff;          // No fixed expected value

    typedef enum logic [2:0] {
        op_alloc, op_alu, op_mul, op_alu_mul, op_flush, op_drain, op_read
    } op_e;

    typedef struct packed {
        op_e       op;
        arch_reg_t dest;
        logic      wr;
        pc_t       pc;
        int        ta;                                     // Allocation index
        int        tb;                                     // Second index for alu_mul
        data_t     va;
        data_t     vb;
        data_t     exp;
    } row_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        arch_reg_t        dest;
        logic             wr;
        logic             done;                            // Result accepted by a port
        data_t            value;
    } entry_t;

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    logic             alloc_valid, alloc_reg_write, alloc_ready;
    logic             alu_valid, alu_ready, mul_valid, mul_ready;
    logic             flush_valid, commit_valid, commit_reg_write;
    logic [TAG_W-1:0] alloc_tag, alu_tag, mul_tag, flush_tag;
    arch_reg_t        alloc_dest, commit_dest, rd_addr;
    pc_t              alloc_pc;
    data_t            alu_value, mul_value, commit_value, rd_data;

    row_t             rows[$];
    entry_t           model[$];                            // Live entries, oldest first
    logic [TAG_W-1:0] alloc_tags [64];                     // Tag returned per allocation
    int               n_alloc = 0;
    logic [TAG_W-1:0] exp_tail = '0;                       // Next tag decode should get
    data_t            shadow [32] = '{default: '0};        // Architectural state mirror
    logic [31:0]      lcg_state = 32'h3608_9251;
    int               value_errs = 0;
    int               other_errs = 0;
    int               cycle_limit = 0;
    int               cycles = 0;

    retire_top #(.ROB_DEPTH(ROB_DEPTH)) u_retire_top (.*);

    always #20 clk = ~clk;

    task automatic add_row(op_e op, int dest, int wr, int pc, int ta, int tb,
                           data_t va, data_t vb, data_t exp);
        row_t r;
        r.op   = op;
        r.dest = arch_reg_t'(dest);
        r.wr   = wr[0];
        r.pc   = pc_t'(pc);
        r.ta   = ta;
        r.tb   = tb;
        r.va   = va;
        r.vb   = vb;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    `include "retire_vectors.svh"

    function automatic data_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic data_t pick_value(data_t v);
        if (v === lcg_v) begin
            return lcg_next();
        end
        return v;
    endfunction

    task automatic report_mismatch(string name, data_t exp, data_t got);
        $display("FAIL %s: expected %h, got %h at %0t", name, exp, got, $time);
        value_errs++;
    endtask

    task automatic report_error(string msg);
        $display("ERROR %s at %0t", msg, $time);
        other_errs++;
    endtask

    // Model entry picks up its value when a port accepts the result
    task automatic complete_entry(logic [TAG_W-1:0] tag, data_t val);
        int hit;
        hit = 0;
        foreach (model[i]) begin
            if (model[i].tag == tag) begin
                model[i].done  = 1'b1;
                model[i].value = val;
                hit            = 1;
            end
        end
        if (hit == 0) report_error("result accepted for a tag with no live entry");
    endtask

    task automatic do_alloc(row_t r);
        entry_t e;
        alloc_valid     = 1'b1;
        alloc_dest      = r.dest;
        alloc_reg_write = r.wr;
        alloc_pc        = r.pc;
        #1;
        if (r.exp === 32'd1) begin                         // Buffer expected full
            if (alloc_ready) report_error("alloc_ready high with every entry live");
            if (model.size() != ROB_DEPTH) report_error("buffer full at the wrong entry count");
            alloc_valid = 1'b0;                            // Dropped before the edge
        end else begin
            while (!alloc_ready) begin
                @(negedge clk);
                #1;
            end
            if (alloc_tag !== exp_tail) begin
                report_mismatch("alloc_tag", data_t'(exp_tail), data_t'(alloc_tag));
            end
            e = '{tag: alloc_tag, dest: r.dest, wr: r.wr, done: 1'b0, value: '0};
            model.push_back(e);
            alloc_tags[n_alloc] = alloc_tag;
            n_alloc++;
            exp_tail++;
        end
        @(negedge clk);
        alloc_valid = 1'b0;
    endtask

    // Each port holds its fields until its own ready
    task automatic do_results(row_t r);
        logic alu_took;
        logic mul_took;
        alu_valid = r.op != op_mul;
        mul_valid = r.op != op_alu;
        alu_tag   = alloc_tags[r.ta];
        mul_tag   = alloc_tags[r.op == op_alu_mul ? r.tb : r.ta];
        alu_value = pick_value(r.va);
        mul_value = pick_value(r.op == op_alu_mul ? r.vb : r.va);
        while (alu_valid || mul_valid) begin
            #1;
            alu_took = alu_valid && alu_ready;
            mul_took = mul_valid && mul_ready;
            if (alu_took && mul_took) report_error("both result ports granted in one cycle");
            if (alu_took) complete_entry(alu_tag, alu_value);
            if (mul_took) complete_entry(mul_tag, mul_value);
            @(negedge clk);
            if (alu_took) alu_valid = 1'b0;
            if (mul_took) mul_valid = 1'b0;
        end
    endtask

    // Branch entry stays, everything younger leaves the model
    task automatic do_flush(row_t r);
        int keep;
        flush_valid = 1'b1;
        flush_tag   = alloc_tags[r.ta];
        #1;
        if (alloc_ready) report_error("alloc_ready high during a flush");
        keep = model.size();
        foreach (model[i]) begin
            if (model[i].tag == flush_tag) keep = i + 1;
        end
        while (model.size() > keep) model.delete(model.size() - 1);
        exp_tail = flush_tag + 1'b1;
        @(negedge clk);
        flush_valid = 1'b0;
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 32; i++) begin
            rd_addr = arch_reg_t'(i);
            #1;
            if (rd_data !== shadow[i]) report_mismatch("rd_data", shadow[i], rd_data);
            @(negedge clk);
        end
    endtask

    task automatic drain_and_sweep();
        while (model.size() != 0) @(negedge clk);
        @(negedge clk);                                    // Last commit reaches the file
        check_all_regs();
    endtask

    task automatic read_reg(row_t r);
        rd_addr = r.dest;
        #1;
        if (rd_data !== shadow[r.dest]) report_mismatch("rd_data", shadow[r.dest], rd_data);
        if (r.exp !== no_exp && rd_data !== r.exp) report_mismatch("rd_data", r.exp, rd_data);
        @(negedge clk);
    endtask

    // Every commit retires the oldest model entry
    always @(negedge clk) begin
        entry_t e;
        if (!rst && commit_valid) begin
            if (model.size() == 0) begin
                report_error("commit with no outstanding entry");
            end else begin
                e = model.pop_front();
                if (!e.done) report_error("commit before the entry's result was accepted");
                if (commit_dest !== e.dest) begin
                    report_mismatch("commit_dest", data_t'(e.dest), data_t'(commit_dest));
                end
                if (commit_reg_write !== e.wr) begin
                    report_mismatch("commit_reg_write", data_t'(e.wr), data_t'(commit_reg_write));
                end
                if (commit_value !== e.value) report_mismatch("commit_value", e.value, commit_value);
                if (e.wr && e.dest != '0) shadow[e.dest] = e.value;
            end
        end
    end

    initial begin
        alloc_valid     = 1'b0;
        alloc_dest      = '0;
        alloc_reg_write = 1'b0;
        alloc_pc        = '0;
        alu_valid       = 1'b0;
        alu_tag         = '0;
        alu_value       = '0;
        mul_valid       = 1'b0;
        mul_tag         = '0;
        mul_value       = '0;
        flush_valid     = 1'b0;
        flush_tag       = '0;
        rd_addr         = '0;
        build_vectors();
        cycle_limit = 50 * rows.size() + 200;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        #1;
        if (commit_valid !== 1'b0) report_error("commit_valid high after reset");
        if (alloc_ready !== 1'b1) report_error("alloc_ready low after reset");
        if (alu_ready || mul_ready) report_error("result ready high with no request");
        @(negedge clk);
        check_all_regs();
        foreach (rows[i]) begin
            case (rows[i].op)
                op_alloc:                   do_alloc(rows[i]);
                op_alu, op_mul, op_alu_mul: do_results(rows[i]);
                op_flush:                   do_flush(rows[i]);
                op_drain:                   drain_and_sweep();
                default:                    read_reg(rows[i]);
            endcase
        end
        $display("Errors %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        report_error("timeout, the DUT stopped responding to a handshake");
        $display("Errors %0d value mismatches, %0d other failures", value_errs, other_errs);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verification
source/retire_pkg.sv
source/completion_arbiter.sv
source/reorder_buffer.sv
source/arch_regfile.sv
source/retire_top.sv
verification/tb_retire_top.sv

// ==== Bender.yml ====
package:
  name: retire_backend

sources:
  - files:
      - source/retire_pkg.sv
      - source/completion_arbiter.sv
      - source/reorder_buffer.sv
      - source/arch_regfile.sv
      - source/retire_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_retire_top.sv
